// File: sim.f
+incdir+tb
verilog/ooo_cfg_pkg.sv
verilog/ooo_types_pkg.sv
verilog/rob.sv
verilog/issue_router.sv
verilog/alu_unit.sv
verilog/muldiv_unit.sv
verilog/cdb_arbiter.sv
verilog/ooo_backend_top.sv
tb/tb_ooo_backend.sv

// File: tb/tb_ooo_tasks.svh
// Expected result of one op from the ISA rules
function automatic logic [ooo_cfg_pkg::XLEN-1:0] model_value(
        input ooo_types_pkg::dispatch_t d);
    case (d.op)
        ooo_cfg_pkg::ADD: return d.a + d.b;
        ooo_cfg_pkg::SUB: return d.a - d.b;
        ooo_cfg_pkg::AND: return d.a & d.b;
        ooo_cfg_pkg::OR:  return d.a | d.b;
        ooo_cfg_pkg::XOR: return d.a ^ d.b;
        ooo_cfg_pkg::SLT: return ($signed(d.a) < $signed(d.b)) ? 32'd1 : 32'd0;
        ooo_cfg_pkg::MUL: return d.a * d.b;                             // Low word only
        ooo_cfg_pkg::DIV: return (d.b == 0) ? '1 : d.a / d.b;           // Unsigned
        default:          return '0;                                    // Branches
    endcase
endfunction

function automatic logic model_taken(input ooo_types_pkg::dispatch_t d);
    if (d.op == ooo_cfg_pkg::BEQ) return d.a == d.b;
    if (d.op == ooo_cfg_pkg::BNE) return d.a != d.b;
    return 1'b0;
endfunction

function automatic ooo_types_pkg::dispatch_t make_op(input ooo_cfg_pkg::op_e op,
        input logic [31:0] a, input logic [31:0] b);
    ooo_types_pkg::dispatch_t d;
    d.op        = op;
    d.rd        = 5'($urandom);
    d.reg_write = 1'($urandom); // Some ops leave rd untouched
    d.a         = a;
    d.b         = b;
    d.pc        = next_pc;
    d.imm       = 32'($urandom % 1024) << 2; // Word-aligned offset
    next_pc     = next_pc + 4;
    return d;
endfunction

task automatic check_value(input string name, input logic [31:0] got,
        input logic [31:0] exp);
    if (got !== exp) begin
        $display("FAIL %s got %h expected %h", name, got, exp);
        errors++;
    end
endtask

// One-cycle dispatch strobe that queues the expected commit when owed
task automatic send(input ooo_types_pkg::dispatch_t d, input bit owed);
    ooo_types_pkg::commit_t e;
    dispatch_valid = 1'b1;
    dispatch       = d;
    if (owed) begin
        e.rd        = d.rd;
        e.value     = model_value(d);
        e.reg_write = d.reg_write && !model_taken(d); // Taken branch writes nothing
        e.pc        = d.pc;
        e.flush     = model_taken(d);
        exp_q.push_back(e);
        if (e.flush) exp_redirect.push_back(d.pc + d.imm);
    end
    @(posedge clk);
    #2;
    dispatch_valid = 1'b0;
endtask

task automatic wait_commits();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < TIMEOUT) begin
        @(posedge clk);
        #2;
        n++;
    end
    if (exp_q.size() != 0) begin
        $display("ERROR: timeout with %0d commits still missing", exp_q.size());
        errors++;
        exp_q.delete();
        exp_redirect.delete();
    end
endtask

task automatic wait_div_busy(input logic level);
    int n;
    n = 0;
    while (div_busy !== level && n < TIMEOUT) begin
        @(posedge clk);
        #2;
        n++;
    end
    if (div_busy !== level) begin
        $display("ERROR: timeout waiting for div_busy to become %0b", level);
        errors++;
    end
endtask

task automatic report_test(input string name, input int start);
    if (errors == start) begin
        tests_passed++;
        $display("Test %s: PASS", name);
    end else begin
        tests_failed++;
        $display("Test %s: FAIL with %0d errors", name, errors - start);
    end
endtask

task automatic test_alu_results();
    ooo_cfg_pkg::op_e ops [6];
    ops = '{ooo_cfg_pkg::ADD, ooo_cfg_pkg::SUB, ooo_cfg_pkg::AND,
            ooo_cfg_pkg::OR, ooo_cfg_pkg::XOR, ooo_cfg_pkg::SLT};
    for (int i = 0; i < 12; i++) begin
        send(make_op(ops[i % 6], $urandom, $urandom), 1'b1); // Back to back
    end
    wait_commits();
endtask

task automatic test_out_of_order();
    send(make_op(ooo_cfg_pkg::DIV, $urandom, 32'($urandom % 1000 + 1)), 1'b1); // Slowest first
    send(make_op(ooo_cfg_pkg::ADD, $urandom, $urandom), 1'b1);
    send(make_op(ooo_cfg_pkg::MUL, $urandom, $urandom), 1'b1);
    send(make_op(ooo_cfg_pkg::XOR, $urandom, $urandom), 1'b1);
    send(make_op(ooo_cfg_pkg::MUL, $urandom, $urandom), 1'b1);
    wait_commits();
endtask

task automatic test_div_by_zero();
    send(make_op(ooo_cfg_pkg::DIV, $urandom, 32'h0), 1'b1); // Quotient of all ones
    wait_div_busy(1'b1);
    wait_div_busy(1'b0);
    send(make_op(ooo_cfg_pkg::DIV, $urandom, $urandom | 32'h1), 1'b1);
    wait_commits();
endtask

task automatic test_taken_branch();
    logic [31:0] v;
    v = $urandom;
    send(make_op(ooo_cfg_pkg::BEQ, v, v), 1'b1);
    send(make_op(ooo_cfg_pkg::DIV, $urandom, 32'd7), 1'b0); // Result lands after flush
    send(make_op(ooo_cfg_pkg::ADD, $urandom, $urandom), 1'b0);
    send(make_op(ooo_cfg_pkg::MUL, $urandom, $urandom), 1'b0);
    wait_commits();
    wait_div_busy(1'b0); // Stale quotient now on its way to the CDB
    send(make_op(ooo_cfg_pkg::SUB, $urandom, $urandom), 1'b1);
    send(make_op(ooo_cfg_pkg::MUL, $urandom, $urandom), 1'b1);
    send(make_op(ooo_cfg_pkg::DIV, $urandom, 32'd5), 1'b1);
    wait_commits();
endtask

task automatic test_not_taken_branch();
    logic [31:0] v;
    v = $urandom;
    send(make_op(ooo_cfg_pkg::BNE, v, v), 1'b1);
    send(make_op(ooo_cfg_pkg::ADD, $urandom, $urandom), 1'b1);
    send(make_op(ooo_cfg_pkg::OR, $urandom, $urandom), 1'b1);
    wait_commits();
endtask

task automatic test_full_rob();
    check_value("rob_full", rob_full, 1'b0);
    send(make_op(ooo_cfg_pkg::DIV, $urandom, 32'd3), 1'b1); // Holds the head for 33 cycles
    for (int i = 1; i < ROB_DEPTH; i++) begin
        check_value("rob_full", rob_full, 1'b0);
        send(make_op(ooo_cfg_pkg::MUL, $urandom, $urandom), 1'b1);
    end
    check_value("rob_full", rob_full, 1'b1);
    send(make_op(ooo_cfg_pkg::ADD, $urandom, $urandom), 1'b0); // Ignored while full
    wait_commits();
    check_value("rob_full", rob_full, 1'b0);
    repeat (20) @(posedge clk); // Window for any stray commit
    #2;
endtask

// File: tb/tb_ooo_backend.sv
`timescale 1ns/1ps

module tb_ooo_backend;

    localparam int ROB_DEPTH  = ooo_cfg_pkg::DEF_ROB_DEPTH;
    localparam int MUL_STAGES = ooo_cfg_pkg::DEF_MUL_STAGES;
    localparam int TIMEOUT    = 500; // Cycles allowed per wait loop

    logic                         clk;
    logic                         rst;
    logic                         dispatch_valid;
    ooo_types_pkg::dispatch_t     dispatch;
    logic                         rob_full;
    logic                         div_busy;
    logic                         commit_valid;
    ooo_types_pkg::commit_t       commit;
    logic                         redirect_valid;
    logic [ooo_cfg_pkg::XLEN-1:0] redirect_pc;

    ooo_types_pkg::commit_t       exp_q [$];        // Commits still owed, oldest first
    logic [ooo_cfg_pkg::XLEN-1:0] exp_redirect [$]; // One target per expected flush
    logic [ooo_cfg_pkg::XLEN-1:0] next_pc;          // Program counter of next dispatch
    int                           errors;
    int                           tests_passed;
    int                           tests_failed;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk; // 40 ns period
    end

    ooo_backend_top #(
        .ROB_DEPTH  (ROB_DEPTH),
        .MUL_STAGES (MUL_STAGES)
    ) i_dut (
        .clk, .rst, .dispatch_valid, .dispatch, .rob_full, .div_busy,
        .commit_valid, .commit, .redirect_valid, .redirect_pc
    );

    `include "tb_ooo_tasks.svh"

    // Commit monitor on the falling edge where registered outputs are stable
    always @(negedge clk) begin : commit_monitor
        ooo_types_pkg::commit_t e;
        if (!rst && redirect_valid && !commit_valid) begin
            $display("ERROR: redirect_valid rose without a commit");
            errors++;
        end
        if (!rst && commit_valid) begin
            if (exp_q.size() == 0) begin
                $display("ERROR: unexpected commit of pc %h", commit.pc); // Flushed or dropped op
                errors++;
            end else begin
                e = exp_q.pop_front();
                check_value("commit.pc", commit.pc, e.pc);
                check_value("commit.rd", commit.rd, e.rd);
                check_value("commit.value", commit.value, e.value);
                check_value("commit.reg_write", commit.reg_write, e.reg_write);
                check_value("commit.flush", commit.flush, e.flush);
                check_value("redirect_valid", redirect_valid, e.flush);
                if (e.flush && exp_redirect.size() != 0) begin
                    check_value("redirect_pc", redirect_pc, exp_redirect.pop_front());
                end
            end
        end
    end

    initial begin
        int start;
        void'($urandom(94431)); // Seeds this thread once
        rst            = 1'b1;
        dispatch_valid = 1'b0;
        dispatch       = '0;
        next_pc        = 32'h0000_1000;
        errors         = 0;
        tests_passed   = 0;
        tests_failed   = 0;
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0; // Inputs move 2 ns after the edge from here on

        start = errors;
        test_alu_results();
        report_test("ALU results", start);
        start = errors;
        test_out_of_order();
        report_test("out-of-order completion", start);
        start = errors;
        test_div_by_zero();
        report_test("divide by zero and div_busy", start);
        start = errors;
        test_taken_branch();
        report_test("taken branch", start);
        start = errors;
        test_not_taken_branch();
        report_test("not-taken branch", start);
        start = errors;
        test_full_rob();
        report_test("full ROB", start);

        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: verilog/alu_unit.sv
`timescale 1ns/1ps

module alu_unit (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   issue_valid,
    input  ooo_types_pkg::issue_t  issue,
    output logic                   res_valid,   // One cycle after issue
    output ooo_types_pkg::result_t res
);

    logic [ooo_cfg_pkg::XLEN-1:0] value;
    logic                         taken;

    always_comb begin
        value = '0;    // Branches return zero
        taken = 1'b0;
        case (issue.op)
            ooo_cfg_pkg::ADD: value = issue.a + issue.b;
            ooo_cfg_pkg::SUB: value = issue.a - issue.b;
            ooo_cfg_pkg::AND: value = issue.a & issue.b;
            ooo_cfg_pkg::OR:  value = issue.a | issue.b;
            ooo_cfg_pkg::XOR: value = issue.a ^ issue.b;
            ooo_cfg_pkg::SLT: value = {{(ooo_cfg_pkg::XLEN-1){1'b0}},
                                       $signed(issue.a) < $signed(issue.b)};
            ooo_cfg_pkg::BEQ: taken = (issue.a == issue.b);
            ooo_cfg_pkg::BNE: taken = (issue.a != issue.b);
            default:          value = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) res_valid <= 1'b0;
        else     res_valid <= issue_valid;
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            res.tag    <= issue.tag;
            res.value  <= value;
            res.taken  <= taken;
            res.target <= issue.pc + issue.imm; // Only meaningful when taken
        end
    end

endmodule

// File: verilog/cdb_arbiter.sv
`timescale 1ns/1ps

module cdb_arbiter #(
    parameter int QDEPTH = ooo_cfg_pkg::DEF_ROB_DEPTH // Power of two, never overflows
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   alu_res_valid,
    input  ooo_types_pkg::result_t alu_res,
    input  logic                   mul_res_valid,
    input  ooo_types_pkg::result_t mul_res,
    input  logic                   div_res_valid,
    input  ooo_types_pkg::result_t div_res,
    output logic                   cdb_valid,
    output ooo_types_pkg::result_t cdb_result
);

    localparam int PTR_W = $clog2(QDEPTH);

    ooo_types_pkg::result_t q      [3][QDEPTH]; // One queue per unit
    ooo_types_pkg::result_t push_res [3];
    logic [2:0]             push;
    logic [2:0]             pop;
    logic [PTR_W-1:0]       wr_ptr [3];
    logic [PTR_W-1:0]       rd_ptr [3];
    logic [PTR_W:0]         cnt    [3];
    logic [1:0]             prio;  // Source checked first
    logic [1:0]             grant;

    assign push        = {div_res_valid, mul_res_valid, alu_res_valid};
    assign push_res[0] = alu_res;
    assign push_res[1] = mul_res;
    assign push_res[2] = div_res;

    // Round-robin pick starting at prio
    always_comb begin
        logic [1:0] idx;
        cdb_valid = 1'b0;
        grant     = prio;
        for (int k = 0; k < 3; k++) begin
            idx = (prio + k >= 3) ? 2'(prio + k - 3) : 2'(prio + k);
            if (!cdb_valid && cnt[idx] != 0) begin
                cdb_valid = 1'b1;
                grant     = idx;
            end
        end
        pop = '0;
        if (cdb_valid) pop[grant] = 1'b1;
    end

    assign cdb_result = q[grant][rd_ptr[grant]]; // Head of granted queue

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            prio <= '0;
            for (int k = 0; k < 3; k++) begin
                wr_ptr[k] <= '0;
                rd_ptr[k] <= '0;
                cnt[k]    <= '0;
            end
        end else begin
            if (cdb_valid) prio <= (grant == 2'd2) ? 2'd0 : grant + 1'b1; // Skip past winner
            for (int k = 0; k < 3; k++) begin
                if (push[k]) wr_ptr[k] <= wr_ptr[k] + 1'b1;
                if (pop[k])  rd_ptr[k] <= rd_ptr[k] + 1'b1;
                cnt[k] <= cnt[k] + push[k] - pop[k];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int k = 0; k < 3; k++) begin
            if (push[k]) q[k][wr_ptr[k]] <= push_res[k];
        end
    end

endmodule

// File: verilog/issue_router.sv
`timescale 1ns/1ps

module issue_router (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     alloc_valid,     // ROB took the dispatch
    input  ooo_types_pkg::rob_tag_t  alloc_tag,
    input  ooo_types_pkg::dispatch_t dispatch,
    output logic                     alu_issue_valid,
    output logic                     mul_issue_valid,
    output logic                     div_issue_valid,
    output ooo_types_pkg::issue_t    issue            // Shared by all units
);

    ooo_cfg_pkg::unit_e unit;

    // Op code to unit
    always_comb begin
        case (dispatch.op)
            ooo_cfg_pkg::MUL: unit = ooo_cfg_pkg::UNIT_MUL;
            ooo_cfg_pkg::DIV: unit = ooo_cfg_pkg::UNIT_DIV;
            default:          unit = ooo_cfg_pkg::UNIT_ALU; // Arith, logic, branches
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            alu_issue_valid <= 1'b0;
            mul_issue_valid <= 1'b0;
            div_issue_valid <= 1'b0;
        end else begin
            alu_issue_valid <= alloc_valid && (unit == ooo_cfg_pkg::UNIT_ALU);
            mul_issue_valid <= alloc_valid && (unit == ooo_cfg_pkg::UNIT_MUL);
            div_issue_valid <= alloc_valid && (unit == ooo_cfg_pkg::UNIT_DIV);
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_valid) begin
            issue.tag <= alloc_tag;
            issue.op  <= dispatch.op;
            issue.a   <= dispatch.a;
            issue.b   <= dispatch.b;
            issue.pc  <= dispatch.pc;
            issue.imm <= dispatch.imm;
        end
    end

endmodule

// File: verilog/muldiv_unit.sv
`timescale 1ns/1ps

module muldiv_unit #(
    parameter int MUL_STAGES = ooo_cfg_pkg::DEF_MUL_STAGES
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   mul_issue_valid,
    input  logic                   div_issue_valid,  // Ignored while busy
    input  ooo_types_pkg::issue_t  issue,
    output logic                   mul_res_valid,
    output ooo_types_pkg::result_t mul_res,
    output logic                   div_res_valid,
    output ooo_types_pkg::result_t div_res,
    output logic                   div_busy
);

    localparam int XLEN = ooo_cfg_pkg::XLEN;

    logic [MUL_STAGES-1:0]   mul_vld;               // Valid per stage
    ooo_types_pkg::rob_tag_t mul_tag  [MUL_STAGES];
    logic [XLEN-1:0]         mul_prod [MUL_STAGES]; // Low product word

    ooo_types_pkg::rob_tag_t div_tag;
    logic [XLEN-1:0]         quo;     // Dividend shifts out, quotient shifts in
    logic [XLEN-1:0]         rem;
    logic [XLEN-1:0]         divisor;
    logic [5:0]              step;
    logic [XLEN:0]           rem_sh;
    logic [XLEN:0]           diff;
    logic                    div_start;

    assign div_start = div_issue_valid && !div_busy;
    assign rem_sh    = {rem, quo[XLEN-1]};        // Bring down next dividend bit
    assign diff      = rem_sh - {1'b0, divisor};  // Sign bit set means restore

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mul_vld       <= '0;
            div_busy      <= 1'b0;
            div_res_valid <= 1'b0;
            step          <= '0;
        end else begin
            mul_vld       <= {mul_vld[MUL_STAGES-2:0], mul_issue_valid};
            div_res_valid <= 1'b0;
            if (div_start) begin
                div_busy <= 1'b1;
                step     <= '0;
            end else if (div_busy) begin
                step <= step + 1'b1;
                if (step == XLEN - 1) begin // Last iteration
                    div_busy      <= 1'b0;
                    div_res_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        mul_tag[0]  <= issue.tag;
        mul_prod[0] <= issue.a * issue.b; // Truncates to low word
        for (int s = 1; s < MUL_STAGES; s++) begin
            mul_tag[s]  <= mul_tag[s-1];
            mul_prod[s] <= mul_prod[s-1];
        end
        if (div_start) begin
            div_tag <= issue.tag;
            quo     <= issue.a;
            rem     <= '0;
            divisor <= issue.b;
        end else if (div_busy) begin
            if (diff[XLEN]) begin
                rem <= rem_sh[XLEN-1:0];
                quo <= {quo[XLEN-2:0], 1'b0};
            end else begin
                rem <= diff[XLEN-1:0];
                quo <= {quo[XLEN-2:0], 1'b1}; // Zero divisor always lands here
            end
        end
    end

    assign mul_res_valid  = mul_vld[MUL_STAGES-1];
    assign mul_res.tag    = mul_tag[MUL_STAGES-1];
    assign mul_res.value  = mul_prod[MUL_STAGES-1];
    assign mul_res.taken  = 1'b0;
    assign mul_res.target = '0;

    assign div_res.tag    = div_tag;
    assign div_res.value  = quo;
    assign div_res.taken  = 1'b0;
    assign div_res.target = '0;

endmodule

// File: verilog/ooo_backend_top.sv
`timescale 1ns/1ps

module ooo_backend_top #(
    parameter int ROB_DEPTH  = ooo_cfg_pkg::DEF_ROB_DEPTH,
    parameter int MUL_STAGES = ooo_cfg_pkg::DEF_MUL_STAGES
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         dispatch_valid,
    input  ooo_types_pkg::dispatch_t     dispatch,
    output logic                         rob_full,       // Do not dispatch
    output logic                         div_busy,       // Do not dispatch a DIV
    output logic                         commit_valid,
    output ooo_types_pkg::commit_t       commit,
    output logic                         redirect_valid,
    output logic [ooo_cfg_pkg::XLEN-1:0] redirect_pc
);

    logic                    alloc_valid;
    ooo_types_pkg::rob_tag_t alloc_tag;
    logic                    alu_issue_valid;
    logic                    mul_issue_valid;
    logic                    div_issue_valid;
    ooo_types_pkg::issue_t   issue;
    logic                    alu_res_valid;
    ooo_types_pkg::result_t  alu_res;
    logic                    mul_res_valid;
    ooo_types_pkg::result_t  mul_res;
    logic                    div_res_valid;
    ooo_types_pkg::result_t  div_res;
    logic                    cdb_valid;
    ooo_types_pkg::result_t  cdb_result;

    rob #(.ROB_DEPTH(ROB_DEPTH)) u_rob (
        .clk, .rst, .dispatch_valid, .dispatch, .cdb_valid, .cdb_result,
        .alloc_valid, .alloc_tag, .rob_full, .commit_valid, .commit,
        .redirect_valid, .redirect_pc
    );

    issue_router u_router (
        .clk, .rst, .alloc_valid, .alloc_tag, .dispatch,
        .alu_issue_valid, .mul_issue_valid, .div_issue_valid, .issue
    );

    alu_unit u_alu (
        .clk, .rst, .issue_valid(alu_issue_valid), .issue,
        .res_valid(alu_res_valid), .res(alu_res)
    );

    muldiv_unit #(.MUL_STAGES(MUL_STAGES)) u_muldiv (
        .clk, .rst, .mul_issue_valid, .div_issue_valid, .issue,
        .mul_res_valid, .mul_res, .div_res_valid, .div_res, .div_busy
    );

    // Queue depth equals ROB size so no queue can overflow
    cdb_arbiter #(.QDEPTH(ROB_DEPTH)) u_arb (
        .clk, .rst, .alu_res_valid, .alu_res, .mul_res_valid, .mul_res,
        .div_res_valid, .div_res, .cdb_valid, .cdb_result
    );

endmodule

// File: verilog/ooo_cfg_pkg.sv
package ooo_cfg_pkg;

    localparam int XLEN           = 32; // Data word width
    localparam int REG_W          = 5;  // Architectural register number width
    localparam int DEF_ROB_DEPTH  = 16; // Default ROB entries, power of two
    localparam int DEF_MUL_STAGES = 3;  // Default multiplier latency

    typedef enum logic [3:0] {
        ADD = 4'd0,
        SUB = 4'd1,
        AND = 4'd2,
        OR  = 4'd3,
        XOR = 4'd4,
        SLT = 4'd5, // Signed compare
        MUL = 4'd6, // Low word of product
        DIV = 4'd7, // Unsigned quotient
        BEQ = 4'd8,
        BNE = 4'd9
    } op_e;

    // Execution unit selected by the router
    typedef enum logic [1:0] {
        UNIT_ALU = 2'd0,
        UNIT_MUL = 2'd1,
        UNIT_DIV = 2'd2
    } unit_e;

endpackage

// File: verilog/ooo_types_pkg.sv
package ooo_types_pkg;

    // Index bits plus one epoch bit on top
    localparam int TAG_W = $clog2(ooo_cfg_pkg::DEF_ROB_DEPTH) + 1;

    typedef logic [TAG_W-1:0] rob_tag_t;

    typedef struct packed {
        ooo_cfg_pkg::op_e              op;
        logic [ooo_cfg_pkg::REG_W-1:0] rd;        // Destination register
        logic                          reg_write; // Writes rd at commit
        logic [ooo_cfg_pkg::XLEN-1:0]  a;         // Operand values already read
        logic [ooo_cfg_pkg::XLEN-1:0]  b;
        logic [ooo_cfg_pkg::XLEN-1:0]  pc;
        logic [ooo_cfg_pkg::XLEN-1:0]  imm;       // Branch offset
    } dispatch_t;

    typedef struct packed {
        rob_tag_t                     tag;
        ooo_cfg_pkg::op_e             op;
        logic [ooo_cfg_pkg::XLEN-1:0] a;
        logic [ooo_cfg_pkg::XLEN-1:0] b;
        logic [ooo_cfg_pkg::XLEN-1:0] pc;
        logic [ooo_cfg_pkg::XLEN-1:0] imm;
    } issue_t;

    typedef struct packed {
        rob_tag_t                     tag;
        logic [ooo_cfg_pkg::XLEN-1:0] value;
        logic                         taken;  // Branch resolved taken
        logic [ooo_cfg_pkg::XLEN-1:0] target; // Branch destination
    } result_t;

    typedef struct packed {
        logic [ooo_cfg_pkg::REG_W-1:0] rd;
        logic [ooo_cfg_pkg::XLEN-1:0]  value;
        logic                          reg_write;
        logic [ooo_cfg_pkg::XLEN-1:0]  pc;
        logic                          flush; // Taken branch retired
    } commit_t;

endpackage

// File: verilog/rob.sv
`timescale 1ns/1ps

module rob #(
    parameter int ROB_DEPTH = ooo_cfg_pkg::DEF_ROB_DEPTH // Power of two
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         dispatch_valid,
    input  ooo_types_pkg::dispatch_t     dispatch,
    input  logic                         cdb_valid,
    input  ooo_types_pkg::result_t       cdb_result,
    output logic                         alloc_valid,    // Same cycle as dispatch
    output ooo_types_pkg::rob_tag_t      alloc_tag,
    output logic                         rob_full,
    output logic                         commit_valid,
    output ooo_types_pkg::commit_t       commit,
    output logic                         redirect_valid,
    output logic [ooo_cfg_pkg::XLEN-1:0] redirect_pc
);

    localparam int IDX_W = $clog2(ROB_DEPTH);

    typedef struct packed {
        logic                          reg_write;
        logic [ooo_cfg_pkg::REG_W-1:0] rd;
        logic [ooo_cfg_pkg::XLEN-1:0]  pc;
        logic [ooo_cfg_pkg::XLEN-1:0]  value;
        logic                          taken;
        logic [ooo_cfg_pkg::XLEN-1:0]  target;
        logic                          epoch; // Epoch at allocation
    } entry_t;

    entry_t               entries [ROB_DEPTH]; // Payload only
    logic [ROB_DEPTH-1:0] valid;               // Allocated
    logic [ROB_DEPTH-1:0] ready;               // Result written back
    logic [IDX_W-1:0]     head;                // Oldest entry
    logic [IDX_W-1:0]     tail;                // Next free slot
    logic [IDX_W:0]       count;
    logic                 epoch;               // Current epoch, flips on flush
    logic                 retire;
    logic                 flush;
    logic                 wb_ok;
    logic [IDX_W-1:0]     wb_idx;
    entry_t               head_e;

    assign rob_full    = (count == ROB_DEPTH);
    assign alloc_valid = dispatch_valid && !rob_full; // Strobe while full is dropped

    always_comb begin
        alloc_tag               = '0;
        alloc_tag[IDX_W-1:0]    = tail;
        alloc_tag[IDX_W]        = epoch;
    end

    // Direct index match, stale epoch or free slot drops the result
    assign wb_idx = cdb_result.tag[IDX_W-1:0];
    assign wb_ok  = cdb_valid && valid[wb_idx] &&
                    (entries[wb_idx].epoch == cdb_result.tag[IDX_W]);

    assign head_e = entries[head];
    assign retire = valid[head] && ready[head];
    assign flush  = retire && head_e.taken; // Branches predicted not-taken

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid          <= '0;
            ready          <= '0;
            head           <= '0;
            tail           <= '0;
            count          <= '0;
            epoch          <= 1'b0;
            commit_valid   <= 1'b0;
            redirect_valid <= 1'b0;
        end else begin
            commit_valid   <= retire;
            redirect_valid <= flush;
            if (wb_ok) begin
                ready[wb_idx] <= 1'b1;
            end
            if (alloc_valid) begin
                valid[tail] <= 1'b1;
                ready[tail] <= 1'b0;
                tail        <= tail + 1'b1; // Wraps at power-of-two depth
            end
            if (retire) begin
                valid[head] <= 1'b0;
                ready[head] <= 1'b0;
                head        <= head + 1'b1;
            end
            count <= count + alloc_valid - retire;
            if (flush) begin
                valid <= '0;           // Discard every younger entry
                ready <= '0;
                tail  <= head + 1'b1;  // Roll back to just past the branch
                count <= '0;
                epoch <= ~epoch;       // In-flight results become stale
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_valid) begin
            entries[tail].reg_write <= dispatch.reg_write;
            entries[tail].rd        <= dispatch.rd;
            entries[tail].pc        <= dispatch.pc;
            entries[tail].epoch     <= epoch;
        end
        if (wb_ok) begin
            entries[wb_idx].value  <= cdb_result.value;
            entries[wb_idx].taken  <= cdb_result.taken;
            entries[wb_idx].target <= cdb_result.target;
        end
        if (retire) begin
            commit.rd        <= head_e.rd;
            commit.value     <= head_e.value;
            commit.reg_write <= head_e.reg_write && !head_e.taken; // Taken branch writes nothing
            commit.pc        <= head_e.pc;
            commit.flush     <= flush;
            redirect_pc      <= head_e.target;
        end
    end

endmodule
